//--- source/arcade_io_pkg.sv
package arcade_io_pkg;

	// ==============================
	// Bus and strobe types
	// ==============================

	// Processor bus as seen by the I/O section, wr is the write level
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;
	} cpu_bus_t;

	// One-hot selects, the *_wr strobes already carry the write level
	typedef struct packed {
		logic palette;
		logic scroll;
		logic watchdog;
		logic inputs;
		logic latch_wr;
		logic bank_wr;
		logic sound_on_wr;
		logic sound_cmd_wr;
	} io_sel_t;

	// Palette byte in BBGGGRRR order, red sits in the low bits
	typedef struct packed {
		logic [1:0] blue;
		logic [2:0] green;
		logic [2:0] red;
	} pal_fields_t;

	// The CPU sees the raw byte while scanout sees the colour fields
	typedef union packed {
		logic [7:0]  raw;
		pal_fields_t fields;
	} pal_word_u;

	typedef struct packed {
		logic [4:0] red;
		logic [4:0] green;
		logic [4:0] blue;
	} rgb_t;

	// Outputs of the LS259 main latch that the board still uses
	typedef struct packed {
		logic irq_en;
		logic stars_en;
		logic sound_mute;
		logic flip_x;
		logic flip_y;
	} latch_t;

	// ==============================
	// Address map
	// ==============================

	// Compared against addr[15:4]
	localparam logic [11:0] PAGE_PALETTE  = 12'h800;
	localparam logic [11:0] PAGE_SCROLL   = 12'h810;
	localparam logic [11:0] PAGE_WATCHDOG = 12'h812;
	localparam logic [11:0] PAGE_DSW2     = 12'h816;
	localparam logic [11:0] PAGE_IN0      = 12'h818;
	localparam logic [11:0] PAGE_IN1      = 12'h81A;
	localparam logic [11:0] PAGE_IN2      = 12'h81C;
	localparam logic [11:0] PAGE_DSW1     = 12'h81E;

	// Write-only ports, compared against addr[15:8]
	localparam logic [7:0] PAGE_LATCH     = 8'h82;
	localparam logic [7:0] PAGE_BANK      = 8'h83;
	localparam logic [7:0] PAGE_SOUND_ON  = 8'h86;
	localparam logic [7:0] PAGE_SOUND_CMD = 8'h87;

	// Pulled-up data bus value when nothing drives it
	localparam logic [7:0] OPEN_BUS = 8'hFF;

endpackage

//--- source/bus_decoder.sv
`timescale 1ns/100ps

module bus_decoder (
	input  logic                   clk_49m,
	input  logic                   reset,
	input  arcade_io_pkg::cpu_bus_t bus_i,
	input  logic [7:0]             pal_rdata_i,
	input  logic [7:0]             scroll_rdata_i,
	input  logic [7:0]             controls_dip_i,
	output arcade_io_pkg::io_sel_t sel_o,
	output logic                   cen_6m_o,
	output logic                   cen_3m_o,
	output logic                   cs_dsw1_o,
	output logic                   cs_dsw2_o,
	output logic [7:0]             cpu_rdata_o
);
	import arcade_io_pkg::*;

	// ==============================
	// Clock enables
	// ==============================

	// 49.152 MHz divided by 8 and by 16
	logic [3:0] div;

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			div <= 4'd0;
		end else begin
			div <= div + 4'd1;
		end
	end

	// Both enables line up on the same edge once every 16 clocks
	assign cen_6m_o = (div[2:0] == 3'd0);
	assign cen_3m_o = (div == 4'd0);

	// ==============================
	// Address decode
	// ==============================

	logic [11:0] page;
	logic [7:0]  port;
	logic        cs_in0;
	logic        cs_in1;
	logic        cs_in2;

	assign page = bus_i.addr[15:4];
	assign port = bus_i.addr[15:8];

	// Switch pages are also exported, the sound board answers them
	assign cs_dsw1_o = (page == PAGE_DSW1);
	assign cs_dsw2_o = (page == PAGE_DSW2);
	assign cs_in0    = (page == PAGE_IN0);
	assign cs_in1    = (page == PAGE_IN1);
	assign cs_in2    = (page == PAGE_IN2);

	assign sel_o.palette  = (page == PAGE_PALETTE);
	assign sel_o.scroll   = (page == PAGE_SCROLL);
	assign sel_o.watchdog = (page == PAGE_WATCHDOG);
	assign sel_o.inputs   = cs_dsw1_o | cs_dsw2_o | cs_in0 | cs_in1 | cs_in2;

	// Write-only ports ignore the low address byte
	assign sel_o.latch_wr     = (port == PAGE_LATCH) & bus_i.wr;
	assign sel_o.bank_wr      = (port == PAGE_BANK) & bus_i.wr;
	assign sel_o.sound_on_wr  = (port == PAGE_SOUND_ON) & bus_i.wr;
	assign sel_o.sound_cmd_wr = (port == PAGE_SOUND_CMD) & bus_i.wr;

	// ==============================
	// CPU read data
	// ==============================

	// Same-cycle path from the address, priority follows the board
	always_comb begin
		if (sel_o.palette) begin
			cpu_rdata_o = pal_rdata_i;
		end else if (sel_o.scroll) begin
			cpu_rdata_o = scroll_rdata_i;
		end else if (sel_o.watchdog) begin
			cpu_rdata_o = OPEN_BUS;
		end else if (sel_o.inputs) begin
			cpu_rdata_o = controls_dip_i;
		end else begin
			// ROM and RAM regions live outside this block
			cpu_rdata_o = OPEN_BUS;
		end
	end

endmodule

//--- source/io_registers.sv
`timescale 1ns/100ps

module io_registers (
	input  logic                    clk_49m,
	input  logic                    reset,
	input  arcade_io_pkg::cpu_bus_t bus_i,
	input  arcade_io_pkg::io_sel_t  sel_i,
	input  logic                    cen_6m_i,
	input  logic                    cen_3m_i,
	output logic [3:0]              bank_o,
	output logic [7:0]              scroll_o,
	output arcade_io_pkg::latch_t   latch_o
);
	import arcade_io_pkg::*;

	// Scroll byte is written on the pixel enable and read back by the CPU
	always_ff @(posedge clk_49m) begin
		if (cen_6m_i && sel_i.scroll && bus_i.wr) begin
			scroll_o <= bus_i.wdata;
		end
	end

	// Bank and latch sit on the slower 3 MHz enable
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			bank_o  <= 4'd0;
			latch_o <= '0;
		end else if (cen_3m_i) begin
			// Only nine banks are fitted, but the full nibble is kept
			if (sel_i.bank_wr) begin
				bank_o <= bus_i.wdata[3:0];
			end
			// LS259 addressable latch, A2..A0 pick the output and D0 is the value
			if (sel_i.latch_wr) begin
				case (bus_i.addr[2:0])
					3'd0: latch_o.irq_en     <= bus_i.wdata[0];
					3'd4: latch_o.stars_en   <= bus_i.wdata[0];
					3'd5: latch_o.sound_mute <= bus_i.wdata[0];
					3'd6: latch_o.flip_x     <= bus_i.wdata[0];
					3'd7: latch_o.flip_y     <= bus_i.wdata[0];
					// Q1 to Q3 drive coin counters and payout, not modelled
					default: begin
					end
				endcase
			end
		end
	end

endmodule

//--- source/palette_file.sv
`timescale 1ns/100ps

module palette_file (
	input  logic                    clk_49m,
	input  arcade_io_pkg::cpu_bus_t bus_i,
	input  arcade_io_pkg::io_sel_t  sel_i,
	input  logic [3:0]              pixel_i,
	output logic [7:0]              rdata_o,
	output arcade_io_pkg::rgb_t     rgb_o
);
	import arcade_io_pkg::*;

	// Sixteen flops rather than a RAM so the CPU and scanout read at once
	pal_word_u pal_mem [16];
	pal_word_u pix_word;

	always_ff @(posedge clk_49m) begin
		if (sel_i.palette && bus_i.wr) begin
			pal_mem[bus_i.addr[3:0]].raw <= bus_i.wdata;
		end
	end

	// CPU read-back of the addressed entry
	assign rdata_o = pal_mem[bus_i.addr[3:0]].raw;

	// ==============================
	// Pixel to RGB
	// ==============================

	assign pix_word = pal_mem[pixel_i];

	// Widen to 5 bits by repeating the top bits so full scale stays full scale
	assign rgb_o.red   = {pix_word.fields.red, pix_word.fields.red[2:1]};
	assign rgb_o.green = {pix_word.fields.green, pix_word.fields.green[2:1]};
	// Blue has only 2 bits, so the pair appears twice plus its MSB
	assign rgb_o.blue  = {pix_word.fields.blue, pix_word.fields.blue,
		pix_word.fields.blue[1]};

endmodule

//--- source/sound_strobes.sv
`timescale 1ns/100ps

module sound_strobes #(
	parameter int STRETCH_LEN = 16
) (
	input  logic                   clk_49m,
	input  logic                   reset,
	input  arcade_io_pkg::io_sel_t sel_i,
	output logic                   sound_cmd_o,
	output logic                   sound_irq_o
);
	// Counter must reach STRETCH_LEN
	localparam int CNT_W = $clog2(STRETCH_LEN + 1);

	logic [1:0] trig;
	logic [1:0] pulse;

	// Channel 0 is the command strobe, channel 1 the sound interrupt
	assign trig = {sel_i.sound_on_wr, sel_i.sound_cmd_wr};

	for (genvar g = 0; g < 2; g++) begin : g_stretch
		logic [CNT_W-1:0] cnt;
		logic             q;

		// Reload while the strobe lasts, drop the output once the count has run out
		always_ff @(posedge clk_49m) begin
			if (!reset) begin
				cnt <= '0;
				q   <= 1'b0;
			end else if (trig[g]) begin
				cnt <= CNT_W'(STRETCH_LEN);
				q   <= 1'b1;
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else begin
				q <= 1'b0;
			end
		end

		assign pulse[g] = q;
	end

	// The sound board samples on its own 3 MHz enable, hence the stretch
	assign sound_cmd_o = pulse[0];
	assign sound_irq_o = pulse[1];

endmodule

//--- source/vblank_irq.sv
`timescale 1ns/100ps

module vblank_irq (
	input  logic clk_49m,
	input  logic reset,
	input  logic cen_6m_i,
	input  logic vblank_i,
	input  logic irq_en_i,
	output logic irq_n_o
);
	logic vblank_q;
	logic frame_odd;

	// The game expects an interrupt on every other frame
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			vblank_q  <= 1'b0;
			frame_odd <= 1'b0;
			irq_n_o   <= 1'b1;
		end else if (cen_6m_i) begin
			vblank_q <= vblank_i;
			// Clearing the enable is also the acknowledge
			if (!irq_en_i) begin
				irq_n_o <= 1'b1;
			end else if (vblank_i && !vblank_q) begin
				frame_odd <= ~frame_odd;
				// Fire on the first edge of each pair, then hold low
				if (!frame_odd) begin
					irq_n_o <= 1'b0;
				end
			end
		end
	end

endmodule

//--- source/tutankham_io_top.sv
`timescale 1ns/100ps

module tutankham_io_top #(
	parameter int STRETCH_LEN = 16
) (
	input  logic                    clk_49m,
	input  logic                    reset,
	input  arcade_io_pkg::cpu_bus_t bus_i,
	input  logic [7:0]              controls_dip_i,
	input  logic [3:0]              pixel_i,
	input  logic                    vblank_i,
	output logic [7:0]              cpu_rdata_o,
	output arcade_io_pkg::rgb_t     rgb_o,
	output logic [3:0]              bank_o,
	output arcade_io_pkg::latch_t   latch_o,
	output logic                    cs_dsw1_o,
	output logic                    cs_dsw2_o,
	output logic                    sound_cmd_o,
	output logic                    sound_irq_o,
	output logic                    irq_n_o
);
	import arcade_io_pkg::*;

	io_sel_t    sel;
	logic       cen_6m;
	logic       cen_3m;
	logic [7:0] pal_rdata;
	logic [7:0] scroll;

	// Decode, enables and read mux
	bus_decoder u_bus_decoder (
		.clk_49m(clk_49m), .reset(reset), .bus_i(bus_i),
		.pal_rdata_i(pal_rdata), .scroll_rdata_i(scroll),
		.controls_dip_i(controls_dip_i), .sel_o(sel),
		.cen_6m_o(cen_6m), .cen_3m_o(cen_3m),
		.cs_dsw1_o(cs_dsw1_o), .cs_dsw2_o(cs_dsw2_o),
		.cpu_rdata_o(cpu_rdata_o)
	);

	io_registers u_io_registers (
		.clk_49m(clk_49m), .reset(reset), .bus_i(bus_i), .sel_i(sel),
		.cen_6m_i(cen_6m), .cen_3m_i(cen_3m),
		.bank_o(bank_o), .scroll_o(scroll), .latch_o(latch_o)
	);

	palette_file u_palette_file (
		.clk_49m(clk_49m), .bus_i(bus_i), .sel_i(sel), .pixel_i(pixel_i),
		.rdata_o(pal_rdata), .rgb_o(rgb_o)
	);

	// Strobes toward the sound board
	sound_strobes #(.STRETCH_LEN(STRETCH_LEN)) u_sound_strobes (
		.clk_49m(clk_49m), .reset(reset), .sel_i(sel),
		.sound_cmd_o(sound_cmd_o), .sound_irq_o(sound_irq_o)
	);

	vblank_irq u_vblank_irq (
		.clk_49m(clk_49m), .reset(reset), .cen_6m_i(cen_6m),
		.vblank_i(vblank_i), .irq_en_i(latch_o.irq_en), .irq_n_o(irq_n_o)
	);

endmodule

//--- verif/tutankham_io_checker.sv
`timescale 1ns/100ps

module tutankham_io_checker #(
	parameter int STRETCH_LEN = 16
) (
	input logic                   clk_49m,
	input logic                   reset,
	input arcade_io_pkg::io_sel_t sel_i,
	input arcade_io_pkg::latch_t  latch_i,
	input logic [3:0]             bank_i,
	input logic                   sound_cmd_i,
	input logic                   sound_irq_i,
	input logic                   irq_n_i
);
	import arcade_io_pkg::*;

	localparam int IDLE_MAX = STRETCH_LEN + 8;

	int fail_count = 0;
	int cmd_idle;
	int irq_idle;

	// Clocks since the last strobe cycle of each channel, saturating past the stretch
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			cmd_idle <= IDLE_MAX;
			irq_idle <= IDLE_MAX;
		end else begin
			cmd_idle <= sel_i.sound_cmd_wr ? 0 : ((cmd_idle < IDLE_MAX) ? cmd_idle + 1 : cmd_idle);
			irq_idle <= sel_i.sound_on_wr ? 0 : ((irq_idle < IDLE_MAX) ? irq_idle + 1 : irq_idle);
		end
	end

	// ==============================
	// Reset, stretch and IRQ rules
	// ==============================

	a_reset_state: assert property (@(posedge clk_49m) !reset |=> (!sound_cmd_i && !sound_irq_i
		&& irq_n_i && latch_i == '0 && bank_i == 4'd0))
	else begin
		fail_count++;
		$error("outputs are not in their reset state one clock after reset");
	end

	// The output drops on the clock after its idle count reaches the stretch plus one
	a_cmd_stretch: assert property (@(posedge clk_49m) disable iff (!reset)
		$fell(sound_cmd_i) |-> cmd_idle == STRETCH_LEN + 1)
	else begin
		fail_count++;
		$error("sound_cmd_o pulse length differs from the stretch length");
	end

	a_irq_stretch: assert property (@(posedge clk_49m) disable iff (!reset)
		$fell(sound_irq_i) |-> irq_idle == STRETCH_LEN + 1)
	else begin
		fail_count++;
		$error("sound_irq_o pulse length differs from the stretch length");
	end

	// The IRQ flop only fires when it saw irq_en high on the same edge
	a_irq_needs_enable: assert property (@(posedge clk_49m) disable iff (!reset)
		$fell(irq_n_i) |-> $past(latch_i.irq_en))
	else begin
		fail_count++;
		$error("irq_n_o fell while irq_en was low");
	end

endmodule

bind tutankham_io_top tutankham_io_checker #(.STRETCH_LEN(STRETCH_LEN)) u_checker (
	.clk_49m(clk_49m), .reset(reset), .sel_i(sel), .latch_i(latch_o), .bank_i(bank_o),
	.sound_cmd_i(sound_cmd_o), .sound_irq_i(sound_irq_o), .irq_n_i(irq_n_o)
);

//--- verif/tb_tutankham_io.sv
`timescale 1ns/100ps

module tb_tutankham_io;
	import arcade_io_pkg::*;

	localparam int STRETCH_LEN = 16;
	localparam int WAIT_LIMIT  = 64;

	logic       clk_49m;
	logic       reset;
	cpu_bus_t   bus;
	logic [7:0] controls_dip;
	logic [3:0] pixel;
	logic       vblank;
	logic [7:0] cpu_rdata;
	rgb_t       rgb;
	logic [3:0] bank;
	latch_t     latch;
	logic       cs_dsw1;
	logic       cs_dsw2;
	logic       sound_cmd;
	logic       sound_irq;
	logic       irq_n;

	integer     seed;
	int         errors;
	int         checks;
	int         tests;
	int         test_errors;
	string      test_name;
	logic [7:0] pal_ref [16];
	latch_t     latch_ref;

	tutankham_io_top #(.STRETCH_LEN(STRETCH_LEN)) u_tutankham_io_top (
		.clk_49m(clk_49m), .reset(reset), .bus_i(bus), .controls_dip_i(controls_dip),
		.pixel_i(pixel), .vblank_i(vblank), .cpu_rdata_o(cpu_rdata), .rgb_o(rgb),
		.bank_o(bank), .latch_o(latch), .cs_dsw1_o(cs_dsw1), .cs_dsw2_o(cs_dsw2),
		.sound_cmd_o(sound_cmd), .sound_irq_o(sound_irq), .irq_n_o(irq_n)
	);

	initial begin
		clk_49m = 1'b0;
		forever #50 clk_49m = ~clk_49m;
	end

	// ==============================
	// Helpers
	// ==============================

	task automatic check_value(input string what, input int exp, input int got);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("error %s %s: expected %0h, actual %0h", test_name, what, exp, got);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("%s: %s", test_name, msg);
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = errors;
		tests++;
	endtask

	task automatic end_test();
		$display("test %s finished with %0d errors", test_name, errors - test_errors);
	endtask

	// Sixteen clocks always contain one 3 MHz enable
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		bus = '{addr: addr, wdata: data, wr: 1'b1};
		repeat (16) @(negedge clk_49m);
		bus.wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		bus = '{addr: addr, wdata: 8'h00, wr: 1'b0};
		@(negedge clk_49m);
		data = cpu_rdata;
	endtask

	// Vblank is sampled on the 6 MHz enable, so both phases span two enables
	task automatic vblank_pulse();
		vblank = 1'b1;
		repeat (16) @(negedge clk_49m);
		vblank = 1'b0;
		repeat (16) @(negedge clk_49m);
	endtask

	task automatic wait_irq_released();
		int guard;
		guard = 0;
		while (!irq_n && guard < WAIT_LIMIT) begin
			@(negedge clk_49m);
			guard++;
		end
		if (!irq_n) begin
			note_failure("irq_n_o did not return high after irq_en was cleared");
		end
	endtask

	function automatic logic sound_level(input bit irq_side);
		return irq_side ? sound_irq : sound_cmd;
	endfunction

	// One-cycle write, then count the clocks the chosen output stays high
	task automatic stretch_width(input logic [15:0] addr, input bit irq_side, output int width);
		int guard;
		guard = 0;
		width = 0;
		bus = '{addr: addr, wdata: 8'h01, wr: 1'b1};
		@(negedge clk_49m);
		bus.wr = 1'b0;
		while (!sound_level(irq_side) && guard < WAIT_LIMIT) begin
			@(negedge clk_49m);
			guard++;
		end
		if (!sound_level(irq_side)) begin
			note_failure("sound output never rose after its strobe");
		end
		while (sound_level(irq_side) && width < WAIT_LIMIT) begin
			width++;
			@(negedge clk_49m);
		end
		if (sound_level(irq_side)) begin
			note_failure("sound output stayed high far past its stretch");
		end
	endtask

	// Palette byte is BBGGGRRR, each channel widened by repeating its top bits
	function automatic rgb_t expand_pixel(input logic [7:0] b);
		rgb_t c;
		c.red   = {b[2:0], b[2:1]};
		c.green = {b[5:3], b[5:4]};
		c.blue  = {b[7:6], b[7:6], b[7]};
		return c;
	endfunction

	// Main latch model, D0 lands on the output picked by A2..A0
	function automatic latch_t latch_update(input latch_t cur, input int q_index, input logic v);
		latch_t nxt;
		nxt = cur;
		case (q_index)
			0: nxt.irq_en = v;
			4: nxt.stars_en = v;
			5: nxt.sound_mute = v;
			6: nxt.flip_x = v;
			7: nxt.flip_y = v;
			default: begin
			end
		endcase
		return nxt;
	endfunction

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		logic [7:0]  rd;
		int          width;
		logic [15:0] in_pages [5];
		logic [15:0] open_addrs [6];
		errors = 0;
		checks = 0;
		tests = 0;
		seed = 32'h9cc8_0adc;
		reset = 1'b0;
		bus = '0;
		controls_dip = 8'h00;
		pixel = 4'd0;
		vblank = 1'b0;
		latch_ref = '0;
		repeat (3) @(negedge clk_49m);
		reset = 1'b1;

		begin_test("reset_state");
		check_value("sound_cmd_o", 0, sound_cmd);
		check_value("sound_irq_o", 0, sound_irq);
		check_value("irq_n_o", 1, irq_n);
		check_value("latch_o", 0, latch);
		check_value("bank_o", 0, bank);
		end_test();

		begin_test("palette");
		for (int i = 0; i < 16; i++) begin
			pal_ref[i] = 8'($random(seed));
			cpu_write(16'h8000 + 16'(i), pal_ref[i]);
		end
		for (int i = 0; i < 16; i++) begin
			cpu_read(16'h8000 + 16'(i), rd);
			check_value($sformatf("entry %0d", i), pal_ref[i], rd);
		end
		for (int i = 0; i < 16; i++) begin
			pixel = 4'(i);
			@(negedge clk_49m);
			check_value($sformatf("rgb of pixel %0d", i), expand_pixel(pal_ref[i]), rgb);
		end
		end_test();

		begin_test("registers");
		cpu_write(16'h8300, 8'hA7);
		check_value("bank_o", 4'h7, bank);
		cpu_write(16'h8300, 8'h05);
		check_value("bank_o", 4'h5, bank);
		cpu_write(16'h8100, 8'h5C);
		cpu_read(16'h8100, rd);
		check_value("scroll", 8'h5C, rd);
		// Upper data bits are set on purpose, only D0 should reach the latch
		for (int v = 1; v >= 0; v--) begin
			for (int a = 0; a < 8; a++) begin
				cpu_write(16'h8200 + 16'(a), 8'hFE | 8'(v));
				latch_ref = latch_update(latch_ref, a, v[0]);
				check_value($sformatf("latch after Q%0d", a), latch_ref, latch);
			end
		end
		end_test();

		begin_test("reads");
		in_pages = '{16'h8160, 16'h8180, 16'h81A0, 16'h81C0, 16'h81E0};
		for (int i = 0; i < 5; i++) begin
			controls_dip = 8'($random(seed));
			cpu_read(in_pages[i], rd);
			check_value($sformatf("input page %h", in_pages[i]), controls_dip, rd);
			check_value("cs_dsw2_o", (i == 0), cs_dsw2);
			check_value("cs_dsw1_o", (i == 4), cs_dsw1);
		end
		open_addrs = '{16'h8120, 16'h0000, 16'h6000, 16'h8200, 16'h8800, 16'hC000};
		for (int i = 0; i < 6; i++) begin
			cpu_read(open_addrs[i], rd);
			check_value($sformatf("open read %h", open_addrs[i]), 8'hFF, rd);
		end
		end_test();

		begin_test("sound_strobes");
		stretch_width(16'h8700, 1'b0, width);
		check_value("sound_cmd_o width", STRETCH_LEN + 1, width);
		stretch_width(16'h8600, 1'b1, width);
		check_value("sound_irq_o width", STRETCH_LEN + 1, width);
		end_test();

		begin_test("vblank_irq");
		cpu_write(16'h8200, 8'h01);
		for (int p = 1; p <= 4; p++) begin
			vblank_pulse();
			check_value($sformatf("irq_n_o after pulse %0d", p), 0, irq_n);
		end
		// Acknowledge leaves the frame toggle where it was
		cpu_write(16'h8200, 8'h00);
		wait_irq_released();
		cpu_write(16'h8200, 8'h01);
		vblank_pulse();
		check_value("irq_n_o first pulse after enable", 0, irq_n);
		cpu_write(16'h8200, 8'h00);
		wait_irq_released();
		cpu_write(16'h8200, 8'h01);
		vblank_pulse();
		check_value("irq_n_o second pulse", 1, irq_n);
		vblank_pulse();
		check_value("irq_n_o third pulse", 0, irq_n);
		cpu_write(16'h8200, 8'h00);
		wait_irq_released();
		for (int p = 1; p <= 2; p++) begin
			vblank_pulse();
			check_value($sformatf("irq_n_o disabled pulse %0d", p), 1, irq_n);
		end
		end_test();

		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests, checks,
			errors, u_tutankham_io_top.u_checker.fail_count);
		if (errors == 0 && u_tutankham_io_top.u_checker.fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- flist.f
source/arcade_io_pkg.sv
source/bus_decoder.sv
source/io_registers.sv
source/palette_file.sv
source/sound_strobes.sv
source/vblank_irq.sv
source/tutankham_io_top.sv
verif/tutankham_io_checker.sv
verif/tb_tutankham_io.sv

//--- Makefile
TOP = tb_tutankham_io

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
